/* lsu_defs.svh */
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// bus widths shared by the load/store unit
`define LSU_ADDR_W 32
`define LSU_DATA_W 32

// one strobe per data byte
`define LSU_STRB_W 4

`endif

/* lsu_pkg.sv */
`include "lsu_defs.svh"

package lsu_pkg;

  // load functions, unknown codes act as a word load
  typedef enum logic [2:0] {
    ld_bs = 3'd0,
    ld_bu = 3'd1,
    ld_hs = 3'd2,
    ld_hu = 3'd3,
    ld_w  = 3'd4
  } load_func_e;

  // store functions, unknown codes act as a word store
  typedef enum logic [2:0] {
    st_b = 3'd0,
    st_h = 3'd1,
    st_w = 3'd2
  } store_func_e;

  // AW payload
  typedef logic [`LSU_ADDR_W-1:0] addr_t;

  // W payload, data and strobes already in lane position
  typedef struct packed {
    logic [`LSU_DATA_W-1:0] data;
    logic [`LSU_STRB_W-1:0] strb;
  } w_beat_t;

endpackage

/* lsu_chan_slot.sv */
`timescale 1ns/100ps

module lsu_chan_slot #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rstn,
  input  logic     push,
  input  payload_t push_data,
  input  logic     ready,
  output logic     space,
  output logic     valid,
  output payload_t data
);

  logic     park_valid;
  payload_t park_data;
  logic     fire;
  logic     out_free;

  assign fire     = valid & ready;
  // output entry can take new data this edge
  assign out_free = ~valid | fire;

  // a new request is only taken while the park entry is empty
  assign space = ~park_valid;

  always_ff @(posedge clk) begin
    if (rstn) begin
      valid      <= 1'b0;
      park_valid <= 1'b0;
    end else begin
      if (out_free) begin
        valid <= park_valid | push;
      end
      if (fire) begin
        park_valid <= 1'b0;
      end else if (push & valid) begin
        park_valid <= 1'b1;
      end
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (out_free) begin
      data <= park_valid ? park_data : push_data;
    end
    if (push & valid & ~fire) begin
      park_data <= push_data;
    end
  end

endmodule

/* lsu_load_align.sv */
`timescale 1ns/100ps
`include "lsu_defs.svh"

module lsu_load_align (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   capture,
  input  logic [1:0]             raddr_lo,
  input  lsu_pkg::load_func_e    rfunc,
  input  logic [`LSU_DATA_W-1:0] rdata_mem,
  output logic [`LSU_DATA_W-1:0] rdata
);

  logic [1:0]             off_q;
  lsu_pkg::load_func_e    func_q;
  logic [`LSU_DATA_W-1:0] shifted;

  // offset and function of the read in flight
  always_ff @(posedge clk) begin
    if (rstn) begin
      off_q  <= 2'b00;
      func_q <= lsu_pkg::ld_w;
    end else if (capture) begin
      off_q  <= raddr_lo;
      func_q <= rfunc;
    end
  end

  // addressed byte down to lane 0
  always_comb begin
    case (off_q)
      2'b00:   shifted = rdata_mem;
      2'b01:   shifted = {8'b0, rdata_mem[31:8]};
      2'b10:   shifted = {16'b0, rdata_mem[31:16]};
      2'b11:   shifted = {24'b0, rdata_mem[31:24]};
      default: shifted = rdata_mem;
    endcase
  end

  always_comb begin
    case (func_q)
      lsu_pkg::ld_bs: begin
        rdata = {{24{shifted[7]}}, shifted[7:0]};
      end
      lsu_pkg::ld_bu: begin
        rdata = {24'b0, shifted[7:0]};
      end
      lsu_pkg::ld_hs: begin
        rdata = {{16{shifted[15]}}, shifted[15:0]};
      end
      lsu_pkg::ld_hu: begin
        rdata = {16'b0, shifted[15:0]};
      end
      // word and any unknown code
      default: begin
        rdata = shifted;
      end
    endcase
  end

endmodule

/* lsu_store_align.sv */
`timescale 1ns/100ps
`include "lsu_defs.svh"

module lsu_store_align (
  input  logic [1:0]             waddr_lo,
  input  logic [`LSU_DATA_W-1:0] wdata,
  input  lsu_pkg::store_func_e   wfunc,
  output lsu_pkg::w_beat_t       beat
);

  logic [`LSU_STRB_W-1:0] strb_base;

  // low lanes covered by the access size
  always_comb begin
    case (wfunc)
      lsu_pkg::st_b: strb_base = 4'b0001;
      lsu_pkg::st_h: strb_base = 4'b0011;
      default:       strb_base = 4'b1111;
    endcase
  end

  // upper bytes fall off past lane 3
  always_comb begin
    case (waddr_lo)
      2'b00: begin
        beat.data = wdata;
        beat.strb = strb_base;
      end
      2'b01: begin
        beat.data = {wdata[23:0], 8'b0};
        beat.strb = {strb_base[2:0], 1'b0};
      end
      2'b10: begin
        beat.data = {wdata[15:0], 16'b0};
        beat.strb = {strb_base[1:0], 2'b0};
      end
      2'b11: begin
        beat.data = {wdata[7:0], 24'b0};
        beat.strb = {strb_base[0], 3'b0};
      end
      default: begin
        beat.data = wdata;
        beat.strb = strb_base;
      end
    endcase
  end

endmodule

/* lsu_ctrl.sv */
`timescale 1ns/100ps

module lsu_ctrl (
  input  logic clk,
  input  logic rstn,

  // read request and response
  input  logic rreq_valid,
  output logic rreq_ready,
  output logic arvalid,
  input  logic arready,
  input  logic rvalid,
  output logic rready,
  output logic rres_valid,
  input  logic rres_ready,
  output logic load_capture,

  // write request
  input  logic wreq_valid,
  output logic wreq_ready,
  input  logic aw_space,
  input  logic w_space,
  output logic push,

  // write response
  input  logic bvalid,
  output logic bready,
  output logic wres_valid,
  input  logic wres_ready
);

  logic rd_busy;
  logic ar_fire;
  logic r_fire;
  logic b_fire;
  logic wres_fire;

  // only one read in flight
  assign arvalid    = rreq_valid & ~rd_busy;
  assign rreq_ready = arready & ~rd_busy;

  assign ar_fire      = arvalid & arready;
  assign load_capture = ar_fire;

  // response path passes straight through
  assign rres_valid = rvalid;
  assign rready     = rres_ready;
  assign r_fire     = rvalid & rres_ready;

  always_ff @(posedge clk) begin
    if (rstn) begin
      rd_busy <= 1'b0;
    end else if (ar_fire) begin
      rd_busy <= 1'b1;
    end else if (r_fire) begin
      rd_busy <= 1'b0;
    end
  end

  // AW and W slots are loaded together
  assign wreq_ready = aw_space & w_space;
  assign push       = wreq_valid & wreq_ready;

  // hold the done pulse until the core takes it
  assign bready    = ~wres_valid;
  assign b_fire    = bvalid & bready;
  assign wres_fire = wres_valid & wres_ready;

  always_ff @(posedge clk) begin
    if (rstn) begin
      wres_valid <= 1'b0;
    end else if (b_fire) begin
      wres_valid <= 1'b1;
    end else if (wres_fire) begin
      wres_valid <= 1'b0;
    end
  end

endmodule

/* lsu_top.sv */
`timescale 1ns/100ps
`include "lsu_defs.svh"

module lsu_top (
  input  logic                   clk,
  input  logic                   rstn,

  // core read request
  input  logic [`LSU_ADDR_W-1:0] raddr,
  input  logic [2:0]             rfunc,
  input  logic                   rreq_valid,
  output logic                   rreq_ready,
  // core read response
  output logic [`LSU_DATA_W-1:0] rdata,
  output logic                   rres_valid,
  input  logic                   rres_ready,

  // core write request
  input  logic [`LSU_ADDR_W-1:0] waddr,
  input  logic [`LSU_DATA_W-1:0] wdata,
  input  logic [2:0]             wfunc,
  input  logic                   wreq_valid,
  output logic                   wreq_ready,
  // core write done
  output logic                   wres_valid,
  input  logic                   wres_ready,

  // memory AR and R
  output logic [`LSU_ADDR_W-1:0] araddr,
  output logic                   arvalid,
  input  logic                   arready,
  input  logic [`LSU_DATA_W-1:0] rdata_mem,
  input  logic                   rvalid,
  output logic                   rready,

  // memory AW, W and B
  output logic [`LSU_ADDR_W-1:0] awaddr,
  output logic                   awvalid,
  input  logic                   awready,
  output logic [`LSU_DATA_W-1:0] wdata_mem,
  output logic [`LSU_STRB_W-1:0] wstrb,
  output logic                   wvalid,
  input  logic                   wready,
  input  logic                   bvalid,
  output logic                   bready
);

  logic             load_capture;
  logic             push;
  logic             aw_space;
  logic             w_space;
  lsu_pkg::w_beat_t beat_in;
  lsu_pkg::w_beat_t beat_out;

  assign araddr    = raddr;
  assign wdata_mem = beat_out.data;
  assign wstrb     = beat_out.strb;

  lsu_ctrl u_ctrl (
    .clk          (clk),
    .rstn         (rstn),
    .rreq_valid   (rreq_valid),
    .rreq_ready   (rreq_ready),
    .arvalid      (arvalid),
    .arready      (arready),
    .rvalid       (rvalid),
    .rready       (rready),
    .rres_valid   (rres_valid),
    .rres_ready   (rres_ready),
    .load_capture (load_capture),
    .wreq_valid   (wreq_valid),
    .wreq_ready   (wreq_ready),
    .aw_space     (aw_space),
    .w_space      (w_space),
    .push         (push),
    .bvalid       (bvalid),
    .bready       (bready),
    .wres_valid   (wres_valid),
    .wres_ready   (wres_ready)
  );

  lsu_load_align u_load_align (
    .clk       (clk),
    .rstn      (rstn),
    .capture   (load_capture),
    .raddr_lo  (raddr[1:0]),
    .rfunc     (lsu_pkg::load_func_e'(rfunc)),
    .rdata_mem (rdata_mem),
    .rdata     (rdata)
  );

  lsu_store_align u_store_align (
    .waddr_lo (waddr[1:0]),
    .wdata    (wdata),
    .wfunc    (lsu_pkg::store_func_e'(wfunc)),
    .beat     (beat_in)
  );

  lsu_chan_slot #(
    .payload_t (lsu_pkg::addr_t)
  ) u_aw_slot (
    .clk       (clk),
    .rstn      (rstn),
    .push      (push),
    .push_data (waddr),
    .ready     (awready),
    .space     (aw_space),
    .valid     (awvalid),
    .data      (awaddr)
  );

  lsu_chan_slot #(
    .payload_t (lsu_pkg::w_beat_t)
  ) u_w_slot (
    .clk       (clk),
    .rstn      (rstn),
    .push      (push),
    .push_data (beat_in),
    .ready     (wready),
    .space     (w_space),
    .valid     (wvalid),
    .data      (beat_out)
  );

endmodule

/* tb_mem_model.sv */
`timescale 1ns/100ps

module tb_mem_model (
  input  logic        clk,
  input  logic        rstn,
  input  logic [31:0] araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata_mem,
  output logic        rvalid,
  input  logic        rready,
  input  logic [31:0] awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata_mem,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic        bvalid,
  input  logic        bready
);

  logic [31:0] mem [0:255];
  logic [31:0] lfsr;
  // pending read, address half and data half of a store
  logic        rd_pend, aw_have, w_have, in_reset;
  logic [7:0]  rd_idx, aw_idx;
  logic [31:0] w_data_q;
  logic [3:0]  w_strb_q;
  // cycles left before the next ready or valid
  logic [1:0]  ar_wait, r_wait, aw_wait, w_wait, b_wait;
  logic        ar_fire, r_fire, aw_fire, w_fire, b_fire;
  logic [31:0] ar_addr_s, aw_addr_s, w_data_s;
  logic [3:0]  w_strb_s;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // delay of 0 to 3 cycles, one LFSR step per bit
  function automatic logic [1:0] delay_bits();
    logic [1:0] d;
    d[1] = lfsr[0];
    lfsr = lfsr_next(lfsr);
    d[0] = lfsr[0];
    lfsr = lfsr_next(lfsr);
    return d;
  endfunction

  task automatic step_read();
    if (ar_fire) begin
      rd_pend = 1'b1;
      rd_idx  = ar_addr_s[9:2];
      ar_wait = delay_bits();
      r_wait  = delay_bits();
    end else if (ar_wait != 0) begin
      ar_wait = ar_wait - 2'd1;
    end
    if (r_fire) begin
      rvalid  = 1'b0;
      rd_pend = 1'b0;
    end else if (rd_pend && !rvalid) begin
      if (r_wait == 0) begin
        rvalid    = 1'b1;
        rdata_mem = mem[rd_idx];
      end else begin
        r_wait = r_wait - 2'd1;
      end
    end
    arready = (ar_wait == 0) && !rd_pend;
  endtask

  task automatic step_write();
    if (aw_fire) begin
      aw_have = 1'b1;
      aw_idx  = aw_addr_s[9:2];
      aw_wait = delay_bits();
    end else if (aw_wait != 0) begin
      aw_wait = aw_wait - 2'd1;
    end
    if (w_fire) begin
      w_have   = 1'b1;
      w_data_q = w_data_s;
      w_strb_q = w_strb_s;
      w_wait   = delay_bits();
    end else if (w_wait != 0) begin
      w_wait = w_wait - 2'd1;
    end
    if (b_fire) begin
      bvalid = 1'b0;
    end
    // both halves in, write the enabled bytes
    if (aw_have && w_have && !bvalid) begin
      if (b_wait == 0) begin
        for (int b = 0; b < 4; b++) begin
          if (w_strb_q[b]) begin
            mem[aw_idx][8*b +: 8] = w_data_q[8*b +: 8];
          end
        end
        {aw_have, w_have} = 2'b00;
        bvalid = 1'b1;
        b_wait = delay_bits();
      end else begin
        b_wait = b_wait - 2'd1;
      end
    end
    awready = (aw_wait == 0) && !aw_have;
    wready  = (w_wait == 0) && !w_have;
  endtask

  initial begin
    lfsr = 32'h18f198fc;
    {arready, rvalid, awready, wready, bvalid} = 5'b0;
    rdata_mem = 32'd0;
    forever begin
      @(posedge clk);
      in_reset  = rstn;
      ar_fire   = arvalid & arready;
      r_fire    = rvalid & rready;
      aw_fire   = awvalid & awready;
      w_fire    = wvalid & wready;
      b_fire    = bvalid & bready;
      ar_addr_s = araddr;
      aw_addr_s = awaddr;
      w_data_s  = wdata_mem;
      w_strb_s  = wstrb;
      #5;
      if (in_reset) begin
        {arready, rvalid, awready, wready, bvalid} = 5'b0;
        {rd_pend, aw_have, w_have} = 3'b0;
        {ar_wait, r_wait, aw_wait, w_wait, b_wait} = 10'b0;
      end else begin
        step_read();
        step_write();
      end
    end
  end

endmodule

/* tb_lsu.sv */
`timescale 1ns/100ps
`include "lsu_defs.svh"

module tb_lsu;

  // loads plus stores issued over the whole run
  localparam int num_ops = 99;

  logic                   clk, rstn;
  logic [`LSU_ADDR_W-1:0] raddr, waddr, araddr, awaddr;
  logic [`LSU_DATA_W-1:0] rdata, wdata, rdata_mem, wdata_mem;
  logic [2:0]             rfunc, wfunc;
  logic [`LSU_STRB_W-1:0] wstrb;
  logic                   rreq_valid, rreq_ready, rres_valid, rres_ready;
  logic                   wreq_valid, wreq_ready, wres_valid, wres_ready;
  logic                   arvalid, arready, rvalid, rready;
  logic                   awvalid, awready, wvalid, wready, bvalid, bready;

  logic [31:0] ref_mem [0:255];
  logic [31:0] exp_q [$];
  logic [31:0] lfsr;
  int          n_acc, n_done;

  lsu_top u_dut (.*);

  tb_mem_model u_mem (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = 32'd0;
    for (int k = 0; k < n; k++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return r;
  endfunction

  // every byte depends on the full word index
  function automatic logic [31:0] fill_word(input logic [7:0] i);
    return {i ^ 8'hc3, i + 8'h5d, ~i, {i[3:0], i[7:4]} ^ 8'h81};
  endfunction

  function automatic int load_bytes(input logic [2:0] f);
    if (f == lsu_pkg::ld_bs || f == lsu_pkg::ld_bu) return 1;
    if (f == lsu_pkg::ld_hs || f == lsu_pkg::ld_hu) return 2;
    return 4;
  endfunction

  function automatic int store_bytes(input logic [2:0] f);
    if (f == lsu_pkg::st_b) return 1;
    if (f == lsu_pkg::st_h) return 2;
    return 4;
  endfunction

  function automatic logic [31:0] lane_mask(input int n);
    return (n >= 4) ? 32'hffffffff : ((32'd1 << (8 * n)) - 32'd1);
  endfunction

  // pull the offset back so the access stays inside its word
  function automatic logic [1:0] fit_off(input logic [1:0] off, input int n);
    return (off + n > 4) ? 2'(4 - n) : off;
  endfunction

  function automatic logic [31:0] load_ref(input logic [31:0] word, input logic [1:0] off,
                                           input logic [2:0] f);
    logic [31:0] m;
    logic [31:0] v;
    int          n;
    n = load_bytes(f);
    m = lane_mask(n);
    v = (word >> (8 * off)) & m;
    if ((f == lsu_pkg::ld_bs || f == lsu_pkg::ld_hs) && v[8*n-1]) begin
      v = v | ~m;
    end
    return v;
  endfunction

  function automatic logic [31:0] store_ref(input logic [31:0] old, input logic [31:0] d,
                                            input logic [1:0] off, input logic [2:0] f);
    logic [31:0] m;
    m = lane_mask(store_bytes(f)) << (8 * off);
    return (old & ~m) | ((d << (8 * off)) & m);
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
    assert (act === exp) else begin
      stop_run($sformatf("Fail at %0d ns: %s expected 0x%08h, got 0x%08h",
                         $time, name, exp, act));
    end
  endtask

  task automatic check_reset_state();
    check_val("wreq_ready", wreq_ready, 1);
    check_val("bready", bready, 1);
    check_val("awvalid", awvalid, 0);
    check_val("wvalid", wvalid, 0);
    check_val("wres_valid", wres_valid, 0);
  endtask

  task automatic store_op(input logic [31:0] a, input logic [31:0] d, input logic [2:0] f);
    waddr      = a;
    wdata      = d;
    wfunc      = f;
    wreq_valid = 1'b1;
    do @(posedge clk); while (!wreq_ready);
    #5;
    wreq_valid = 1'b0;
  endtask

  task automatic load_op(input logic [31:0] a, input logic [2:0] f);
    raddr      = a;
    rfunc      = f;
    rreq_valid = 1'b1;
    do @(posedge clk); while (!rreq_ready);
    #5;
    rreq_valid = 1'b0;
    do @(posedge clk); while (!rres_valid);
    #5;
  endtask

  task automatic wait_stores_done();
    while (n_done != n_acc) begin
      @(posedge clk);
      #5;
    end
  endtask

  task automatic rand_store(input int words);
    logic [2:0] f;
    logic [1:0] off;
    f   = rand_bits(2) % 3;
    off = fit_off(rand_bits(2), store_bytes(f));
    store_op((rand_bits(8) % words) * 4 + off, rand_bits(32), f);
  endtask

  task automatic rand_load(input int words);
    logic [2:0] f;
    logic [1:0] off;
    f   = rand_bits(3) % 5;
    off = fit_off(rand_bits(2), load_bytes(f));
    load_op((rand_bits(8) % words) * 4 + off, f);
  endtask

  // all stores are done, so no further done pulse may be pending
  task automatic compare_mem();
    for (int i = 0; i < 256; i++) begin
      check_val($sformatf("mem[%0d]", i), u_mem.mem[i], ref_mem[i]);
    end
    check_val("wres_valid", wres_valid, 0);
  endtask

  // reference memory follows accepted stores and responses are checked here
  always @(posedge clk) begin
    if (!rstn) begin
      if (wreq_valid && wreq_ready) begin
        ref_mem[waddr[9:2]] = store_ref(ref_mem[waddr[9:2]], wdata, waddr[1:0], wfunc);
        n_acc <= n_acc + 1;
      end
      if (rreq_valid && rreq_ready) begin
        exp_q.push_back(load_ref(ref_mem[raddr[9:2]], raddr[1:0], rfunc));
      end
      if (rres_valid && rres_ready) begin
        assert (exp_q.size() > 0) else stop_run("read response arrived with no load pending");
        check_val("rdata", rdata, exp_q.pop_front());
      end
      if (wres_valid && wres_ready) begin
        assert (n_done < n_acc) else stop_run("write done pulse with no store left to finish");
        n_done <= n_done + 1;
      end
    end
  end

  initial begin
    repeat (num_ops * 20 + 200) @(posedge clk);
    stop_run($sformatf("timeout: run still busy after %0d clock cycles", num_ops * 20 + 200));
  end

  initial begin
    logic [31:0] a;
    lfsr = 32'h18f198fc;
    {rstn, rreq_valid, wreq_valid} = 3'b100;
    {rres_ready, wres_ready} = 2'b11;
    {raddr, waddr, wdata, rfunc, wfunc} = '0;
    n_acc  = 0;
    n_done = 0;
    for (int i = 0; i < 256; i++) begin
      ref_mem[i]   = fill_word(i);
      u_mem.mem[i] = fill_word(i);
    end
    repeat (4) begin
      @(posedge clk);
      #5;
      check_reset_state();
    end
    rstn = 1'b0;
    @(posedge clk);
    #5;
    check_reset_state();
    // every load function at every offset inside the word
    for (int f = 0; f < 5; f++) begin
      for (int off = 0; off < 4; off++) begin
        if (off + load_bytes(f) <= 4) begin
          load_op((32 + 4 * f + off) * 4 + off, f);
        end
      end
    end
    // single stores read back as words
    for (int f = 0; f < 3; f++) begin
      for (int off = 0; off < 4; off++) begin
        if (off + store_bytes(f) <= 4) begin
          a = (64 + 4 * f + off) * 4;
          store_op(a + off, rand_bits(32), f);
          wait_stores_done();
          load_op(a, lsu_pkg::ld_w);
        end
      end
    end
    repeat (24) rand_store(64);
    wait_stores_done();
    compare_mem();
    // core holds off the write done
    wres_ready = 1'b0;
    repeat (4) rand_store(64);
    while (!wres_valid) begin
      @(posedge clk);
      #5;
    end
    repeat (8) begin
      @(posedge clk);
      #5;
      check_val("wres_valid", wres_valid, 1);
      check_val("bready", bready, 0);
    end
    wres_ready = 1'b1;
    wait_stores_done();
    // mixed traffic where loads wait for earlier stores
    repeat (40) begin
      if (rand_bits(1)) begin
        rand_store(32);
      end else begin
        wait_stores_done();
        rand_load(32);
      end
    end
    wait_stores_done();
    compare_mem();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* project.f */
+incdir+.
lsu_pkg.sv
lsu_chan_slot.sv
lsu_load_align.sv
lsu_store_align.sv
lsu_ctrl.sv
lsu_top.sv
tb_mem_model.sv
tb_lsu.sv
